// ==== smc_pkg.sv ====
//----------------------------------------------------------
// Shared types, timing values and state encoding for the
// static memory controller
//----------------------------------------------------------

package smc_pkg;

  //----------------------------------------------------------
  // Bus types
  //----------------------------------------------------------
  typedef logic [31:0] data_t;  // One data word
  typedef logic [3:0]  be_t;    // Byte lanes, active low

  // AHB size code, upper hsize bit not carried
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } xfer_size_t;

  // Captured address, full word or word index plus lane offset
  typedef union packed {
    data_t full;                // External address as issued
    struct packed {
      logic [29:0] word_idx;    // Word index
      logic [1:0]  byte_off;    // Selects the byte lanes
    } fields;
  } haddr_u;

  // Access sequencer, one-hot
  typedef enum logic [4:0] {
    IDLE = 5'b00001,            // Waiting for a transfer
    CSLE = 5'b00010,            // Chip select leading edge
    WS   = 5'b00100,            // Strobe window
    CSTE = 5'b01000,            // Trailing edge, bus floats
    DONE = 5'b10000             // Last cycle, ready back high
  } smc_state_t;

  //----------------------------------------------------------
  // External bus timing, in hclk cycles
  //----------------------------------------------------------
  localparam logic [1:0] CSLE_CYCLES = 2'd1;  // Min 1
  localparam logic [7:0] WS_CYCLES   = 8'd3;  // Min 1
  localparam logic [1:0] CSTE_CYCLES = 2'd1;  // Min 1
  localparam logic [7:0] WETE_CYCLES = 8'd1;  // Write strobe early end
  localparam logic [7:0] OETE_CYCLES = 8'd0;  // Read strobe early end

  // AHB codes
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic [1:0] RESP_OKAY     = 2'b00;

endpackage

// ==== smc_counter.sv ====
//----------------------------------------------------------
// Phase counters for leading edge, wait states and
// trailing edge
//----------------------------------------------------------
`timescale 1ns/100ps

module smc_counter (
  input  logic       hclk,
  input  logic       reset,
  input  logic       valid_access,  // Reload all counters
  input  logic       le_enable,
  input  logic       ws_enable,
  input  logic       cste_enable,
  output logic       csle_last,
  output logic       ws_last,
  output logic       cste_last,
  output logic [7:0] ws_count       // Strobe cycles left from next cycle
);

  import smc_pkg::*;

  logic [1:0] csle_cnt;
  logic [7:0] ws_cnt;
  logic [1:0] cste_cnt;

  always_ff @(posedge hclk) begin
    if (reset) begin
      csle_cnt <= 2'd0;
      ws_cnt   <= 8'd0;
      cste_cnt <= 2'd0;
    end else if (valid_access) begin
      csle_cnt <= CSLE_CYCLES;
      ws_cnt   <= WS_CYCLES;
      cste_cnt <= CSTE_CYCLES;
    end else begin
      if (le_enable)   csle_cnt <= csle_cnt - 2'd1;
      if (ws_enable)   ws_cnt   <= ws_cnt - 8'd1;
      if (cste_enable) cste_cnt <= cste_cnt - 2'd1;
    end
  end

  // Phase ends when one cycle is left
  assign csle_last = (csle_cnt == 2'd1);
  assign ws_last   = (ws_cnt == 8'd1);
  assign cste_last = (cste_cnt == 2'd1);

  // Look ahead one cycle so the strobes can be registered
  always_comb begin
    if (le_enable && csle_last) ws_count = WS_CYCLES;      // Entering WS
    else if (ws_enable)         ws_count = ws_cnt - 8'd1;
    else                        ws_count = 8'd0;
  end

endmodule

// ==== smc_state.sv ====
//----------------------------------------------------------
// Access sequencer FSM. Steps through leading edge, wait
// states and trailing edge on the counter flags
//----------------------------------------------------------
`timescale 1ns/100ps

module smc_state (
  input  logic                hclk,
  input  logic                reset,
  input  logic                new_access,
  input  logic                n_read,
  input  logic                csle_last,    // Counter terminal flags
  input  logic                ws_last,
  input  logic                cste_last,
  output smc_pkg::smc_state_t cur_state,
  output logic                valid_access, // Leaving IDLE
  output logic                le_enable,
  output logic                ws_enable,
  output logic                cste_enable,
  output logic                latch_data,   // Sample read data
  output logic                smc_done
);

  import smc_pkg::*;

  smc_state_t next_state;

  //----------------------------------------------------------
  // Next state
  //----------------------------------------------------------
  always_comb begin
    next_state = cur_state;         // Hold by default
    case (cur_state)
      IDLE: begin
        if (new_access) next_state = CSLE;
      end
      CSLE: begin
        if (csle_last) next_state = WS;
      end
      WS: begin
        if (ws_last) next_state = CSTE;
      end
      CSTE: begin
        if (cste_last) next_state = DONE;
      end
      DONE: begin
        next_state = IDLE;          // Always a single cycle
      end
      default: begin
        next_state = IDLE;          // Recover from an illegal code
      end
    endcase
  end

  always_ff @(posedge hclk) begin
    if (reset) cur_state <= IDLE;
    else       cur_state <= next_state;
  end

  //----------------------------------------------------------
  // Decoded controls
  //----------------------------------------------------------
  assign valid_access = (cur_state == IDLE) && new_access;
  assign le_enable    = (cur_state == CSLE);
  assign ws_enable    = (cur_state == WS);
  assign cste_enable  = (cur_state == CSTE);
  assign smc_done     = (cur_state == DONE);

  // Last strobe cycle of a read, data settled on the bus
  assign latch_data   = (cur_state == WS) && ws_last && !n_read;

  //----------------------------------------------------------
  // Checks
  //----------------------------------------------------------
  a_state_onehot: assert property (
    @(posedge hclk) disable iff (reset)
    $onehot(cur_state)
  );

  // Fixed access length, counters and FSM together
  a_access_length: assert property (
    @(posedge hclk) disable iff (reset)
    valid_access |-> ##(CSLE_CYCLES + WS_CYCLES + CSTE_CYCLES + 1) smc_done
  );

endmodule

// ==== smc_addr.sv ====
//----------------------------------------------------------
// External address, chip select and byte lane enables
//----------------------------------------------------------
`timescale 1ns/100ps

module smc_addr (
  input  logic                hclk,
  input  logic                reset,
  input  logic                valid_access,
  input  logic                smc_done,
  input  smc_pkg::haddr_u     addr,
  input  smc_pkg::xfer_size_t xfer_size,
  output smc_pkg::data_t      smc_addr,
  output smc_pkg::be_t        smc_n_be,
  output logic                smc_n_cs
);

  import smc_pkg::*;

  be_t lane_n_be;  // Decoded lanes, active low

  // Little endian, lane 0 on bits 7:0
  always_comb begin
    case (xfer_size)
      SIZE_BYTE: lane_n_be = ~(4'b0001 << addr.fields.byte_off);
      SIZE_HALF: lane_n_be = addr.fields.byte_off[1] ? 4'b0011 : 4'b1100;
      default:   lane_n_be = 4'b0000;  // Full word
    endcase
  end

  // Lanes and chip select held for the whole access
  always_ff @(posedge hclk) begin
    if (reset) begin
      smc_n_be <= 4'hf;
      smc_n_cs <= 1'b1;
    end else if (valid_access) begin
      smc_n_be <= lane_n_be;
      smc_n_cs <= 1'b0;
    end else if (smc_done) begin
      smc_n_be <= 4'hf;
      smc_n_cs <= 1'b1;
    end
  end

  always_ff @(posedge hclk) begin
    if (valid_access) smc_addr <= addr.full;
  end

endmodule

// ==== smc_strobe.sv ====
//----------------------------------------------------------
// Read and write strobes, bus drive enable, busy flag and
// the external data paths
//----------------------------------------------------------
`timescale 1ns/100ps

module smc_strobe (
  input  logic                hclk,
  input  logic                reset,
  input  smc_pkg::smc_state_t cur_state,
  input  logic [7:0]          ws_count,    // Look-ahead strobe count
  input  logic                n_read,
  input  smc_pkg::be_t        smc_n_be,
  input  smc_pkg::data_t      write_data,
  input  smc_pkg::data_t      data_smc,    // From the memory
  input  logic                latch_data,
  output logic                smc_n_rd,
  output logic                smc_n_wr,
  output smc_pkg::be_t        smc_n_we,
  output logic                smc_n_ext_oe,
  output logic                smc_busy,
  output smc_pkg::data_t      smc_data,
  output smc_pkg::data_t      read_data
);

  import smc_pkg::*;

  logic rd_on;     // Read strobe wanted next cycle
  logic wr_on;     // Write strobe wanted next cycle
  logic drive_on;  // We own the data bus next cycle

  // Strobes drop TE cycles before the window closes
  assign rd_on    = !n_read && (ws_count > OETE_CYCLES);
  assign wr_on    = n_read && (ws_count > WETE_CYCLES);
  assign drive_on = n_read && (ws_count != 8'd0);  // Whole window

  //----------------------------------------------------------
  // Registered strobes
  //----------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= 4'hf;
      smc_n_ext_oe <= 1'b1;
    end else begin
      smc_n_rd     <= !rd_on;
      smc_n_wr     <= !wr_on;
      smc_n_we     <= wr_on ? smc_n_be : 4'hf;  // Enabled lanes only
      smc_n_ext_oe <= !drive_on;
    end
  end

  // Busy from the FSM idle bit
  assign smc_busy = (cur_state != IDLE);

  //----------------------------------------------------------
  // Data paths
  //----------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (drive_on) smc_data <= write_data;    // Stable through the write
    if (latch_data) read_data <= data_smc;
  end

  a_strobe_exclusive: assert property (
    @(posedge hclk) disable iff (reset)
    !(!smc_n_rd && !smc_n_wr)
  );

endmodule

// ==== smc_ahb_if.sv ====
//----------------------------------------------------------
// AHB-lite slave front end. Transfer capture, ready
// generation and read data return
//----------------------------------------------------------
`timescale 1ns/100ps

module smc_ahb_if (
  input  logic                hclk,
  input  logic                reset,
  input  smc_pkg::data_t      haddr,
  input  logic [1:0]          htrans,
  input  logic                hsel,
  input  logic                hwrite,
  input  logic [2:0]          hsize,
  input  smc_pkg::data_t      hwdata,
  input  logic                hready,
  input  smc_pkg::data_t      read_data,   // Latched memory data
  input  logic                smc_done,    // Last cycle of access
  output logic                new_access,  // One cycle after capture
  output smc_pkg::haddr_u     addr,
  output smc_pkg::xfer_size_t xfer_size,
  output logic                n_read,      // Low for a read
  output smc_pkg::data_t      write_data,
  output logic                smc_hready,
  output smc_pkg::data_t      smc_hrdata
);

  import smc_pkg::*;

  logic capture;    // Address phase accepted this cycle
  logic in_access;  // Access outstanding on the external bus

  // Valid address phase, only while we are not stalling
  assign capture = hsel && hready && smc_hready &&
                   (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

  //----------------------------------------------------------
  // Control state
  //----------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      new_access <= 1'b0;
      in_access  <= 1'b0;
      n_read     <= 1'b1;
    end else begin
      new_access <= capture;
      // Capture wins so a back-to-back transfer keeps us busy
      if (capture) begin
        in_access <= 1'b1;
        n_read    <= hwrite;        // Read when hwrite low
      end else if (smc_done) begin
        in_access <= 1'b0;
      end
    end
  end

  // Address phase payload
  always_ff @(posedge hclk) begin
    if (capture) begin
      addr.full <= haddr;
      xfer_size <= xfer_size_t'(hsize[1:0]);
    end
  end

  // Data phase follows the address phase by one cycle
  always_ff @(posedge hclk) begin
    if (new_access) write_data <= hwdata;
  end

  // Ready comes back in the DONE cycle so the next transfer can start
  assign smc_hready = !in_access || smc_done;
  assign smc_hrdata = read_data;  // Held until the next read latches

  //----------------------------------------------------------
  // Checks
  //----------------------------------------------------------
  // No second capture while the running access is stalled
  a_no_capture_stalled: assert property (
    @(posedge hclk) disable iff (reset)
    new_access |=> (!new_access) [* CSLE_CYCLES + WS_CYCLES + CSTE_CYCLES + 1]
  );

  // External bus is a single word, no double word transfers
  a_size_fits_bus: assert property (
    @(posedge hclk) disable iff (reset)
    capture |-> (hsize[2] == 1'b0 && hsize[1:0] != 2'b11)
  );

endmodule

// ==== smc_lite.sv ====
//----------------------------------------------------------
// Static memory controller top level
//----------------------------------------------------------
`timescale 1ns/100ps

module smc_lite (
  input  logic           hclk,
  input  logic           reset,
  input  smc_pkg::data_t haddr,
  input  logic [1:0]     htrans,
  input  logic           hsel,
  input  logic           hwrite,
  input  logic [2:0]     hsize,
  input  smc_pkg::data_t hwdata,
  input  logic           hready,
  input  smc_pkg::data_t data_smc,
  output smc_pkg::data_t smc_hrdata,
  output logic           smc_hready,
  output logic [1:0]     smc_hresp,     // Always OKAY
  output smc_pkg::data_t smc_addr,
  output smc_pkg::data_t smc_data,
  output smc_pkg::be_t   smc_n_be,
  output logic           smc_n_cs,
  output logic           smc_n_wr,
  output smc_pkg::be_t   smc_n_we,
  output logic           smc_n_rd,
  output logic           smc_n_ext_oe,
  output logic           smc_busy
);

  import smc_pkg::*;

  // Front end to datapath
  logic       new_access;
  haddr_u     addr;
  xfer_size_t xfer_size;
  logic       n_read;
  data_t      write_data;
  data_t      read_data;

  // Sequencer and counters
  smc_state_t cur_state;
  logic       valid_access;
  logic       le_enable;
  logic       ws_enable;
  logic       cste_enable;
  logic       latch_data;
  logic       smc_done;
  logic       csle_last;
  logic       ws_last;
  logic       cste_last;
  logic [7:0] ws_count;

  assign smc_hresp = RESP_OKAY;

  smc_ahb_if  i_ahb_if  (.*);
  smc_state   i_state   (.*);
  smc_counter i_counter (.*);
  smc_addr    i_addr    (.*);
  smc_strobe  i_strobe  (.*);

endmodule

// ==== tb_smc_lite.sv ====
//----------------------------------------------------------
// Testbench for the static memory controller. Clock, reset,
// SRAM model, golden transfer list, checks and watchdog
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_smc_lite;

  import smc_pkg::*;

  localparam int RESET_CYCLES = 8;
  // Capture edge to the edge that sees ready high again
  localparam int XFER_LATENCY = 2 + CSLE_CYCLES + WS_CYCLES + CSTE_CYCLES;

  logic       hclk = 1'b0;
  logic       reset;
  data_t      haddr;
  logic [1:0] htrans;
  logic       hsel;
  logic       hwrite;
  logic [2:0] hsize;
  data_t      hwdata;
  logic       hready;
  data_t      data_smc;
  data_t      smc_hrdata;
  logic       smc_hready;
  logic [1:0] smc_hresp;
  data_t      smc_addr;
  data_t      smc_data;
  be_t        smc_n_be;
  logic       smc_n_cs;
  logic       smc_n_wr;
  be_t        smc_n_we;
  logic       smc_n_rd;
  logic       smc_n_ext_oe;
  logic       smc_busy;

  data_t      mem [0:63];      // External SRAM, one word per index
  integer     seed;
  bit         loaded = 1'b0;   // Golden list in memory
  logic       xfer_is_write = 1'b0;

  // Golden columns
  int         g_op[$];         // 0 write, 1 read, 2/3 ignored cycle
  data_t      g_addr[$];
  logic [1:0] g_size[$];
  data_t      g_wdata[$];
  be_t        g_be[$];
  data_t      g_rdata[$];

  smc_lite dut_i (.*);

  always #50 hclk = ~hclk;     // 100 ns period

  //----------------------------------------------------------
  // SRAM model
  //----------------------------------------------------------
  assign data_smc = !smc_n_rd ? mem[smc_addr[7:2]] : 32'h0;

  always @(posedge hclk) begin
    if (!smc_n_wr) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (!smc_n_we[lane]) mem[smc_addr[7:2]][lane*8 +: 8] <= smc_data[lane*8 +: 8];
      end
    end
  end

  //----------------------------------------------------------
  // Reporting and compares
  //----------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_be(input string what, input be_t got, input be_t exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
      abort_run($sformatf("[FAIL] time %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // Skips comment lines, keeps complete six column rows
  task automatic load_golden();
    int         fd;
    int         n;
    string      line;
    int         op;
    data_t      a;
    logic [1:0] sz;
    data_t      wd;
    be_t        be;
    data_t      rd;
    fd = $fopen("smc_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open smc_golden.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h", op, a, sz, wd, be, rd);
          if (n == 6) begin
            g_op.push_back(op);
            g_addr.push_back(a);
            g_size.push_back(sz);
            g_wdata.push_back(wd);
            g_be.push_back(be);
            g_rdata.push_back(rd);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //----------------------------------------------------------
  // Bus sequences
  //----------------------------------------------------------
  task automatic run_access(input int idx);
    int lat;
    bit is_read;
    is_read = (g_op[idx] == 1);
    @(posedge hclk);                     // Address phase
    xfer_is_write <= !is_read;
    haddr  <= g_addr[idx];
    htrans <= HTRANS_NONSEQ;
    hsel   <= 1'b1;
    hwrite <= !is_read;
    hsize  <= {1'b0, g_size[idx]};
    @(posedge hclk);                     // Capture edge, data phase starts
    htrans <= 2'b00;
    hsel   <= 1'b0;
    hwdata <= is_read ? 32'h0 : g_wdata[idx];
    lat = 0;
    do begin
      @(posedge hclk);
      lat++;
      @(negedge hclk);
      if (lat == 1) begin               // First CSLE cycle
        check_bit("smc_n_cs in CSLE", smc_n_cs, 1'b0);
        check_be("smc_n_be", smc_n_be, g_be[idx]);
      end
      check_bit("smc_busy during access", smc_busy, 1'b1);
    end while (!smc_hready && lat < XFER_LATENCY);
    check_count("cycles to ready", lat + 1, XFER_LATENCY);  // Next edge completes
    check_resp("smc_hresp", smc_hresp, 2'b00);             // AHB OKAY
    if (is_read) check_data("smc_hrdata", smc_hrdata, g_rdata[idx]);
  endtask

  // Idle htrans (op 2) or hready low (op 3), neither may start an access
  task automatic probe_no_capture(input int idx);
    @(posedge hclk);
    haddr  <= g_addr[idx];
    hsel   <= 1'b1;
    hwrite <= 1'b0;
    hsize  <= 3'b010;
    if (g_op[idx] == 2) begin
      htrans <= 2'b00;
    end else begin
      htrans <= HTRANS_NONSEQ;
      hready <= 1'b0;
    end
    @(posedge hclk);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hready <= 1'b1;
    repeat (3) begin
      @(negedge hclk);
      check_bit("smc_n_cs after ignored cycle", smc_n_cs, 1'b1);
      check_bit("smc_hready after ignored cycle", smc_hready, 1'b1);
    end
  endtask

  // Strobe relations, every cycle
  always @(negedge hclk) begin
    if (!reset) begin
      if ((!smc_n_rd || !smc_n_wr) && smc_n_cs)
        abort_run("read or write strobe active while chip select is high");
      if (!smc_n_rd && !smc_n_wr)
        abort_run("read and write strobes active together");
      if (!smc_n_ext_oe && (!xfer_is_write || smc_n_cs))
        abort_run("data bus driven outside a write access");
    end
  end

  // Watchdog, sized from the golden list
  initial begin
    wait (loaded);
    repeat (g_op.size() * (XFER_LATENCY + 3 + 4) + RESET_CYCLES) @(posedge hclk);
    abort_run("timeout: DUT did not complete all transfers");
  end

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    int gap;
    seed   = 32'h7ae23e65;
    reset  = 1'b1;
    haddr  = 32'h0;
    htrans = 2'b00;
    hsel   = 1'b0;
    hwrite = 1'b0;
    hsize  = 3'b010;
    hwdata = 32'h0;
    hready = 1'b1;
    for (int i = 0; i < 64; i++) mem[i] = 32'h5a000000 ^ (i * 32'h00010203);
    load_golden();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge hclk);
    reset <= 1'b0;
    @(negedge hclk);                     // Everything inactive out of reset
    check_bit("smc_n_cs after reset", smc_n_cs, 1'b1);
    check_bit("smc_n_rd after reset", smc_n_rd, 1'b1);
    check_bit("smc_n_wr after reset", smc_n_wr, 1'b1);
    check_bit("smc_n_ext_oe after reset", smc_n_ext_oe, 1'b1);
    check_be("smc_n_we after reset", smc_n_we, 4'hf);
    check_be("smc_n_be after reset", smc_n_be, 4'hf);
    check_bit("smc_busy after reset", smc_busy, 1'b0);
    check_bit("smc_hready after reset", smc_hready, 1'b1);
    for (int i = 0; i < g_op.size(); i++) begin
      gap = $random(seed) & 3;           // 0 to 3 idle cycles
      repeat (gap) @(posedge hclk);
      if (g_op[i] < 2) run_access(i);
      else probe_no_capture(i);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== compile.f ====
smc_pkg.sv
smc_counter.sv
smc_state.sv
smc_addr.sv
smc_strobe.sv
smc_ahb_if.sv
smc_lite.sv
tb_smc_lite.sv

// ==== smc_golden.txt ====
# op addr size wdata exp_n_be exp_rdata, all hex
# op 0 write, 1 read, 2 idle htrans probe, 3 hready low probe; size 0 byte, 1 half, 2 word
0 00000000 2 11223344 0 00000000
1 00000000 2 00000000 0 11223344
0 00000010 2 aabbccdd 0 00000000
0 00000011 0 0000ee00 d 00000000
1 00000010 2 00000000 0 aabbeedd
0 00000020 2 01020304 0 00000000
0 00000022 1 beef0000 3 00000000
1 00000020 2 00000000 0 beef0304
0 00000030 2 cafef00d 0 00000000
0 00000030 1 00001234 c 00000000
0 00000033 0 55000000 7 00000000
1 00000030 2 00000000 0 55fe1234
2 00000040 2 00000000 f 00000000
3 00000040 2 00000000 f 00000000
0 00000034 2 87654321 0 00000000
0 00000036 0 00990000 b 00000000
1 00000034 2 00000000 0 87994321
1 00000001 0 00000000 d 11223344
1 00000022 1 00000000 3 beef0304
0 000000fc 2 0f0e0d0c 0 00000000
1 000000fc 2 00000000 0 0f0e0d0c
1 00000000 2 00000000 0 11223344
